// ==== flash_rd_defs.svh ====
`ifndef FLASH_RD_DEFS_SVH
`define FLASH_RD_DEFS_SVH

// number of fully associative read buffers
`define FLASH_RD_NUM_BUF 4

// flash word address, the upper part of which selects the page
`define FLASH_RD_ADDR_W 12
`define FLASH_RD_PAGE_W 6

// the bus word and the flash word have the same width
`define FLASH_RD_DATA_W 32

// number of responses that can be outstanding at once
`define FLASH_RD_RSP_DEPTH 4

`endif

// ==== flash_rd_pkg.sv ====
`default_nettype none

`include "flash_rd_defs.svh"

package flash_rd_pkg;

  // life cycle of one read buffer
  typedef enum logic [1:0] {
    BUF_INVALID = 2'd0,
    BUF_WIP     = 2'd1,
    BUF_VALID   = 2'd2
  } buf_state_e;

  // operations that change flash contents behind the buffers
  typedef enum logic [1:0] {
    OP_PROG     = 2'd0,
    OP_PG_ERASE = 2'd1,
    OP_BK_ERASE = 2'd2
  } maint_op_e;

  // a single flash read can be in flight
  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_BUSY = 1'b1
  } rd_state_e;

  typedef struct packed {
    logic [`FLASH_RD_ADDR_W-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    buf_state_e                  state;
    logic                        err;
    logic [`FLASH_RD_ADDR_W-1:0] addr;
    logic [`FLASH_RD_DATA_W-1:0] data;
  } buf_entry_t;

  // buf_sel is the one-hot buffer that answers the request
  // flash marks a request that started its own flash read
  typedef struct packed {
    logic [`FLASH_RD_NUM_BUF-1:0] buf_sel;
    logic                         flash;
  } rsp_entry_t;

  // word as it comes out of the flash macro, with even parity
  typedef struct packed {
    logic [`FLASH_RD_DATA_W-1:0] data;
    logic                        parity;
  } flash_rsp_t;

  typedef struct packed {
    logic [`FLASH_RD_DATA_W-1:0] data;
    logic                        err;
  } rd_rsp_t;

endpackage

`default_nettype wire

// ==== flash_rd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_defs.svh"

module flash_rd_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          buf_en_i,
  input  logic                          req_i,
  input  logic                          flash_ack_i,
  input  logic                          flash_done_i,
  input  logic [`FLASH_RD_NUM_BUF-1:0]  hit_i,
  input  logic [`FLASH_RD_NUM_BUF-1:0]  repl_i,
  input  logic                          all_dep_i,
  input  logic                          fifo_full_i,
  input  logic                          idle_i,
  output logic                          rdy_o,
  output logic                          flash_req_o,
  output logic [`FLASH_RD_NUM_BUF-1:0]  alloc_o,
  output logic [`FLASH_RD_NUM_BUF-1:0]  update_o,
  output logic                          push_o,
  output flash_rd_pkg::rsp_entry_t      push_data_o,
  output logic                          buf_en_o,
  output flash_rd_pkg::rd_state_e       rd_state_o
);

  import flash_rd_pkg::*;

  logic                         buf_en_q;
  logic                         hit;
  logic                         stage_ok;
  logic                         flash_rdy;
  logic                         rd_start;
  logic                         rd_done;
  rd_state_e                    rd_state_q;
  logic [`FLASH_RD_NUM_BUF-1:0] alloc_q;

  //////////////////////////////////////////////////
  // buffer enable
  //////////////////////////////////////////////////

  // the enable may only move while nothing is in flight, otherwise a
  // pending response could look for a buffer that is no longer there
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_en_q <= 1'b0;
    end else if (idle_i) begin
      buf_en_q <= buf_en_i;
    end
  end

  assign buf_en_o = buf_en_q;

  //////////////////////////////////////////////////
  // acceptance and flash handshake
  //////////////////////////////////////////////////

  // hit_i is already qualified with req_i and the enable
  assign hit = |hit_i;

  // the order FIFO needs room, a buffer must be free to allocate,
  // and a pending enable change holds everything back until it lands
  assign stage_ok = ~fifo_full_i & ~all_dep_i & (buf_en_q == buf_en_i);

  // done frees the flash stage in the same cycle, so back to back reads work
  assign rd_done   = (rd_state_q == RD_BUSY) & flash_done_i;
  assign flash_rdy = (rd_state_q == RD_IDLE) | rd_done;

  assign flash_req_o = req_i & ~hit & flash_rdy & stage_ok;
  assign rd_start    = flash_req_o & flash_ack_i;

  // a miss is accepted exactly when the flash takes the read
  assign rdy_o = hit ? stage_ok : rd_start;

  // with buffers off nothing is allocated and the word goes straight out
  assign alloc_o = (rd_start && buf_en_q) ? repl_i : '0;

  assign push_o              = req_i & rdy_o;
  assign push_data_o.buf_sel = hit ? hit_i : alloc_o;
  assign push_data_o.flash   = ~hit;

  // keep the allocated buffer so the returning word lands in it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_state_q <= RD_IDLE;
      alloc_q    <= '0;
    end else if (rd_start) begin
      rd_state_q <= RD_BUSY;
      alloc_q    <= alloc_o;
    end else if (rd_done) begin
      rd_state_q <= RD_IDLE;
    end
  end

  assign update_o   = rd_done ? alloc_q : '0;
  assign rd_state_o = rd_state_q;

endmodule

`default_nettype wire

// ==== flash_rd_buf_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_defs.svh"

module flash_rd_buf_array (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic                                               en_i,
  input  flash_rd_pkg::rd_req_t                              req_data_i,
  input  logic                                               req_i,
  input  logic                                               maint_i,
  input  flash_rd_pkg::maint_op_e                            maint_op_i,
  input  logic [`FLASH_RD_NUM_BUF-1:0]                       alloc_i,
  input  logic [`FLASH_RD_NUM_BUF-1:0]                       update_i,
  input  flash_rd_pkg::rd_rsp_t                              fill_i,
  input  logic [`FLASH_RD_NUM_BUF-1:0]                       dep_i,
  input  logic                                               all_dep_i,
  output logic [`FLASH_RD_NUM_BUF-1:0]                       hit_o,
  output logic [`FLASH_RD_NUM_BUF-1:0]                       repl_o,
  output flash_rd_pkg::buf_entry_t [`FLASH_RD_NUM_BUF-1:0]   entries_o
);

  import flash_rd_pkg::*;

  localparam int NumBuf = `FLASH_RD_NUM_BUF;
  localparam int IdxW   = $clog2(NumBuf);

  buf_state_e                  state_q [NumBuf];
  logic                        err_q   [NumBuf];
  logic [`FLASH_RD_ADDR_W-1:0] addr_q  [NumBuf];
  logic [`FLASH_RD_DATA_W-1:0] data_q  [NumBuf];

  logic [NumBuf-1:0] wipe;
  logic [NumBuf-1:0] inv_cand;
  logic [NumBuf-1:0] val_cand;
  logic [NumBuf-1:0] inv_pick;
  logic [NumBuf-1:0] rr_pick;
  logic [IdxW-1:0]   rr_idx;
  logic [IdxW-1:0]   ptr_q;

  //////////////////////////////////////////////////
  // match and hazard
  //////////////////////////////////////////////////

  always_comb begin
    logic word_match;
    logic page_match;
    for (int i = 0; i < NumBuf; i++) begin
      word_match = addr_q[i] == req_data_i.addr;
      page_match = addr_q[i][`FLASH_RD_ADDR_W-1 -: `FLASH_RD_PAGE_W] ==
                   req_data_i.addr[`FLASH_RD_ADDR_W-1 -: `FLASH_RD_PAGE_W];

      // a buffer still being filled also hits, its answer just waits
      // errored words never hit so that they are read from flash again
      hit_o[i] = req_i & en_i & ~err_q[i] & word_match &
                 (state_q[i] == BUF_VALID || state_q[i] == BUF_WIP);

      // maintenance only comes in while idle, so no buffer is in progress
      wipe[i] = maint_i & (state_q[i] == BUF_VALID) &
                ((maint_op_i == OP_BK_ERASE) |
                 ((maint_op_i == OP_PG_ERASE) & page_match) |
                 ((maint_op_i == OP_PROG) & word_match));

      entries_o[i].state = state_q[i];
      entries_o[i].err   = err_q[i];
      entries_o[i].addr  = addr_q[i];
      entries_o[i].data  = data_q[i];
    end
  end

  //////////////////////////////////////////////////
  // replacement choice
  //////////////////////////////////////////////////

  always_comb begin
    int idx;
    inv_pick = '0;
    rr_pick  = '0;
    rr_idx   = ptr_q;

    // an errored word nobody waits for is as good as an empty buffer
    for (int i = 0; i < NumBuf; i++) begin
      inv_cand[i] = (state_q[i] == BUF_INVALID) |
                    ((state_q[i] == BUF_VALID) & err_q[i] & ~dep_i[i]);
      val_cand[i] = (state_q[i] == BUF_VALID) & ~dep_i[i];
    end

    // walk downwards so the lowest candidate is the last one written
    for (int i = NumBuf - 1; i >= 0; i--) begin
      if (inv_cand[i]) begin
        inv_pick    = '0;
        inv_pick[i] = 1'b1;
      end
    end

    // first free valid buffer at or after the round-robin pointer
    for (int k = NumBuf - 1; k >= 0; k--) begin
      idx = (int'(ptr_q) + k) % NumBuf;
      if (val_cand[idx]) begin
        rr_pick      = '0;
        rr_pick[idx] = 1'b1;
        rr_idx       = IdxW'(idx);
      end
    end

    // the work in progress buffer is never a candidate
    if (|inv_pick) begin
      repl_o = inv_pick;
    end else if (all_dep_i) begin
      repl_o = '0;
    end else begin
      repl_o = rr_pick;
    end
  end

  // the pointer only moves when a valid buffer is actually evicted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (|alloc_i && !(|inv_pick)) begin
      ptr_q <= (rr_idx == IdxW'(NumBuf - 1)) ? '0 : rr_idx + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // buffer storage
  //////////////////////////////////////////////////

  // allocate moves to work in progress, the flash return makes it valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumBuf; i++) begin
        state_q[i] <= BUF_INVALID;
      end
    end else begin
      for (int i = 0; i < NumBuf; i++) begin
        if (!en_i) begin
          state_q[i] <= BUF_INVALID;
        end else if (update_i[i]) begin
          state_q[i] <= BUF_VALID;
        end else if (alloc_i[i]) begin
          state_q[i] <= BUF_WIP;
        end else if (wipe[i]) begin
          state_q[i] <= BUF_INVALID;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumBuf; i++) begin
      if (alloc_i[i]) begin
        addr_q[i] <= req_data_i.addr;
        err_q[i]  <= 1'b0;
      end
      if (update_i[i]) begin
        data_q[i] <= fill_i.data;
        err_q[i]  <= fill_i.err;
      end
    end
  end

endmodule

`default_nettype wire

// ==== flash_rd_rsp_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_defs.svh"

module flash_rd_rsp_fifo (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         push_i,
  input  flash_rd_pkg::rsp_entry_t     push_data_i,
  input  logic                         pop_i,
  output flash_rd_pkg::rsp_entry_t     head_o,
  output logic                         head_valid_o,
  output logic                         full_o,
  output logic [`FLASH_RD_NUM_BUF-1:0] dep_o,
  output logic                         all_dep_o
);

  import flash_rd_pkg::*;

  localparam int Depth  = `FLASH_RD_RSP_DEPTH;
  localparam int PtrW   = $clog2(Depth);
  localparam int CntW   = $clog2(Depth + 1);
  localparam int NumBuf = `FLASH_RD_NUM_BUF;

  rsp_entry_t      mem [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic [CntW-1:0] dep_cnt_q [NumBuf];
  logic            do_push;
  logic            do_pop;

  assign head_valid_o = count_q != '0;
  assign full_o       = count_q == CntW'(Depth);
  assign head_o       = mem[rd_ptr_q];

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & head_valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

  // each buffer counts the queued responses that will read from it
  // and a buffer with a non-zero count must not be replaced
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumBuf; i++) begin
        dep_cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumBuf; i++) begin
        dep_cnt_q[i] <= dep_cnt_q[i] + CntW'(do_push & push_data_i.buf_sel[i]) -
                        CntW'(do_pop & head_o.buf_sel[i]);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NumBuf; i++) begin
      dep_o[i] = dep_cnt_q[i] != '0;
    end
  end

  assign all_dep_o = &dep_o;

endmodule

`default_nettype wire

// ==== flash_rd_rsp.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_defs.svh"

module flash_rd_rsp (
  input  logic                                             en_i,
  input  logic                                             flash_done_i,
  input  flash_rd_pkg::flash_rsp_t                         flash_data_i,
  input  flash_rd_pkg::rsp_entry_t                         head_i,
  input  logic                                             head_valid_i,
  input  flash_rd_pkg::buf_entry_t [`FLASH_RD_NUM_BUF-1:0] entries_i,
  input  flash_rd_pkg::rd_state_e                          rd_state_i,
  output flash_rd_pkg::rd_rsp_t                            fill_o,
  output logic                                             rsp_valid_o,
  output flash_rd_pkg::rd_rsp_t                            rsp_o,
  output logic                                             pop_o,
  output logic                                             idle_o
);

  import flash_rd_pkg::*;

  logic                         parity_ok;
  logic [`FLASH_RD_NUM_BUF-1:0] sel_wip;
  logic [`FLASH_RD_NUM_BUF-1:0] sel_valid;
  logic                         flash_hit;
  logic                         buf_hit;
  rd_rsp_t                      buf_rsp;

  // even parity over data and parity bit, a bad word reads as all ones
  assign parity_ok   = ~^{flash_data_i.data, flash_data_i.parity};
  assign fill_o.data = parity_ok ? flash_data_i.data : '1;
  assign fill_o.err  = ~parity_ok;

  always_comb begin
    buf_rsp = '0;
    for (int i = 0; i < `FLASH_RD_NUM_BUF; i++) begin
      sel_wip[i]   = head_i.buf_sel[i] & (entries_i[i].state == BUF_WIP);
      sel_valid[i] = head_i.buf_sel[i] & (entries_i[i].state == BUF_VALID);
      if (sel_valid[i]) begin
        buf_rsp.data = entries_i[i].data;
        buf_rsp.err  = entries_i[i].err;
      end
    end
  end

  // only one buffer is ever in progress, the one of the read in flight,
  // so a miss at the head whose buffer is still filling is this read
  assign flash_hit = head_valid_i & head_i.flash & (rd_state_i == RD_BUSY) &
                     flash_done_i & (~en_i | (|sel_wip));

  // a miss that lost the race to the head is answered here later
  assign buf_hit = en_i & head_valid_i & (|sel_valid);

  assign rsp_valid_o = flash_hit | buf_hit;
  assign rsp_o       = flash_hit ? fill_o : buf_rsp;
  assign pop_o       = rsp_valid_o;
  assign idle_o      = ~head_valid_i;

endmodule

`default_nettype wire

// ==== flash_rd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_defs.svh"

module flash_rd_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        buf_en_i,
  input  logic                        req_i,
  input  flash_rd_pkg::rd_req_t       req_data_i,
  output logic                        rdy_o,
  input  logic                        maint_i,
  input  flash_rd_pkg::maint_op_e     maint_op_i,
  output logic                        rsp_valid_o,
  output flash_rd_pkg::rd_rsp_t       rsp_o,
  output logic                        idle_o,
  output logic                        flash_req_o,
  input  logic                        flash_ack_i,
  input  logic                        flash_done_i,
  input  flash_rd_pkg::flash_rsp_t    flash_data_i
);

  import flash_rd_pkg::*;

  logic [`FLASH_RD_NUM_BUF-1:0] hit;
  logic [`FLASH_RD_NUM_BUF-1:0] repl;
  logic [`FLASH_RD_NUM_BUF-1:0] alloc;
  logic [`FLASH_RD_NUM_BUF-1:0] update;
  logic [`FLASH_RD_NUM_BUF-1:0] dep;
  logic                         all_dep;
  logic                         fifo_full;
  logic                         push;
  rsp_entry_t                   push_data;
  logic                         pop;
  rsp_entry_t                   head;
  logic                         head_valid;
  logic                         buf_en;
  rd_state_e                    rd_state;
  rd_rsp_t                      fill;
  buf_entry_t [`FLASH_RD_NUM_BUF-1:0] entries;

  // request acceptance and the single flash read
  flash_rd_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .buf_en_i     (buf_en_i),
    .req_i        (req_i),
    .flash_ack_i  (flash_ack_i),
    .flash_done_i (flash_done_i),
    .hit_i        (hit),
    .repl_i       (repl),
    .all_dep_i    (all_dep),
    .fifo_full_i  (fifo_full),
    .idle_i       (idle_o),
    .rdy_o        (rdy_o),
    .flash_req_o  (flash_req_o),
    .alloc_o      (alloc),
    .update_o     (update),
    .push_o       (push),
    .push_data_o  (push_data),
    .buf_en_o     (buf_en),
    .rd_state_o   (rd_state)
  );

  flash_rd_buf_array u_buf_array (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (buf_en),
    .req_data_i (req_data_i),
    .req_i      (req_i),
    .maint_i    (maint_i),
    .maint_op_i (maint_op_i),
    .alloc_i    (alloc),
    .update_i   (update),
    .fill_i     (fill),
    .dep_i      (dep),
    .all_dep_i  (all_dep),
    .hit_o      (hit),
    .repl_o     (repl),
    .entries_o  (entries)
  );

  // keeps answers in request order
  flash_rd_rsp_fifo u_rsp_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_data_i  (push_data),
    .pop_i        (pop),
    .head_o       (head),
    .head_valid_o (head_valid),
    .full_o       (fifo_full),
    .dep_o        (dep),
    .all_dep_o    (all_dep)
  );

  flash_rd_rsp u_rsp (
    .en_i         (buf_en),
    .flash_done_i (flash_done_i),
    .flash_data_i (flash_data_i),
    .head_i       (head),
    .head_valid_i (head_valid),
    .entries_i    (entries),
    .rd_state_i   (rd_state),
    .fill_o       (fill),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .pop_o        (pop),
    .idle_o       (idle_o)
  );

endmodule

`default_nettype wire

// ==== tb_flash_rd_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_defs.svh"

module tb_flash_rd_assert (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         req_i,
  input logic                         rdy_i,
  input logic                         flash_req_i,
  input logic                         flash_ack_i,
  input logic                         rsp_valid_i,
  input logic                         idle_i,
  input logic [`FLASH_RD_NUM_BUF-1:0] hit_i,
  input logic [`FLASH_RD_NUM_BUF-1:0] alloc_i,
  input logic [`FLASH_RD_NUM_BUF-1:0] dep_i
);

  // number of assertion failures so far
  int fail_cnt = 0;

  // requests taken by the DUT whose answer has not come back yet
  int pend_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 0;
    end else begin
      pend_q <= pend_q + int'(req_i && rdy_i) - int'(rsp_valid_i);
    end
  end

  // a flash request may not be withdrawn before the macro takes it
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flash_req_i && !flash_ack_i |=> flash_req_i)
    else begin
      fail_cnt++;
      $error("flash request dropped before ack");
    end

  // a response always belongs to a request that is still waiting
  rsp_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> pend_q != 0)
    else begin
      fail_cnt++;
      $error("response without a waiting request");
    end

  // idle means exactly that no accepted request waits for its answer,
  // so together with the check above no response comes while idle
  idle_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_i == (pend_q == 0))
    else begin
      fail_cnt++;
      $error("idle does not match the requests still waiting");
    end

  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_i))
    else begin
      fail_cnt++;
      $error("more than one buffer hit");
    end

  // a buffer that a queued response still reads from is never taken
  alloc_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(alloc_i) && ((alloc_i & dep_i) == '0))
    else begin
      fail_cnt++;
      $error("buffer allocated twice or while a response needs it");
    end

endmodule

`default_nettype wire

// ==== tb_flash_rd_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_defs.svh"

module tb_flash_rd_chk (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  req_i,
  input flash_rd_pkg::rd_req_t req_data_i,
  input logic                  rdy_i,
  input logic                  rsp_valid_i,
  input flash_rd_pkg::rd_rsp_t rsp_i
);

  import flash_rd_pkg::*;

  // expected answers and their addresses, in request order
  rd_rsp_t                     expect_q [$];
  logic [`FLASH_RD_ADDR_W-1:0] addr_q [$];
  int                          err_cnt = 0;

  // a good word comes back as stored in the macro model
  // a word with broken parity comes back as all ones with err set
  function automatic rd_rsp_t ref_rsp(input logic [`FLASH_RD_ADDR_W-1:0] addr);
    rd_rsp_t r;
    if (tb_flash_rd.bad_word[addr]) begin
      r.data = '1;
      r.err  = 1'b1;
    end else begin
      r.data = tb_flash_rd.flash_mem[addr];
      r.err  = 1'b0;
    end
    return r;
  endfunction

  // memory only changes while idle, so the expected value is fixed at acceptance
  always @(posedge clk_i) begin
    if (rst_ni && req_i && rdy_i) begin
      expect_q.push_back(ref_rsp(req_data_i.addr));
      addr_q.push_back(req_data_i.addr);
    end
  end

  always @(posedge clk_i) begin : compare
    rd_rsp_t                     exp;
    logic [`FLASH_RD_ADDR_W-1:0] addr;
    if (rst_ni && rsp_valid_i) begin
      if (expect_q.size() == 0) begin
        $display("a response arrived at %t with no request waiting for it", $time);
        err_cnt++;
      end else begin
        exp  = expect_q.pop_front();
        addr = addr_q.pop_front();
        if (rsp_i !== exp) begin
          $display("Error at %t: addr %h expected %h err %b, got %h err %b",
                   $time, addr, exp.data, exp.err, rsp_i.data, rsp_i.err);
          err_cnt++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_flash_rd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_defs.svh"

module tb_flash_rd;

  import flash_rd_pkg::*;

  localparam int NumWords  = 1 << `FLASH_RD_ADDR_W;
  // requests per test, in the order the tests run
  localparam int NumReq    = 16 + 16 + 2 + 12 + 20 + 8;
  localparam int MaxCycles = 40 * NumReq + 200;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       buf_en_i;
  logic       req_i;
  rd_req_t    req_data_i;
  logic       rdy_o;
  logic       maint_i;
  maint_op_e  maint_op_i;
  logic       rsp_valid_o;
  rd_rsp_t    rsp_o;
  logic       idle_o;
  logic       flash_req_o;
  logic       flash_ack_i;
  logic       flash_done_i;
  flash_rsp_t flash_data_i;

  // flash macro contents, parity error list and reads per address
  logic [`FLASH_RD_DATA_W-1:0] flash_mem [NumWords];
  logic                        bad_word  [NumWords];
  int                          rd_cnt    [NumWords];

  integer seed       = 32'h7e04;
  logic   slow_flash = 1'b0;
  int     cycle_cnt  = 0;
  int     tb_err     = 0;
  int     last_errs  = 0;
  int     pass_cnt   = 0;
  int     fail_cnt   = 0;

  always #50 clk_i = ~clk_i;

  flash_rd_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .buf_en_i     (buf_en_i),
    .req_i        (req_i),
    .req_data_i   (req_data_i),
    .rdy_o        (rdy_o),
    .maint_i      (maint_i),
    .maint_op_i   (maint_op_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .idle_o       (idle_o),
    .flash_req_o  (flash_req_o),
    .flash_ack_i  (flash_ack_i),
    .flash_done_i (flash_done_i),
    .flash_data_i (flash_data_i)
  );

  tb_flash_rd_chk u_chk (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_data_i  (req_data_i),
    .rdy_i       (rdy_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_i       (rsp_o)
  );

  bind flash_rd_top tb_flash_rd_assert u_assert (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .rdy_i       (rdy_o),
    .flash_req_i (flash_req_o),
    .flash_ack_i (flash_ack_i),
    .rsp_valid_i (rsp_valid_o),
    .idle_i      (idle_o),
    .hit_i       (hit),
    .alloc_i     (alloc),
    .dep_i       (dep)
  );

  //////////////////////////////////////////////////
  // flash macro model
  //////////////////////////////////////////////////

  // one read at a time: ack after 0 to 2 cycles, done 1 to 4 cycles later
  initial begin : flash_model
    int                          d;
    logic [`FLASH_RD_ADDR_W-1:0] a;
    flash_ack_i  = 1'b0;
    flash_done_i = 1'b0;
    flash_data_i = '0;
    for (int i = 0; i < NumWords; i++) begin
      flash_mem[i] = $random(seed);
      bad_word[i]  = 1'b0;
      rd_cnt[i]    = 0;
    end
    forever begin
      @(posedge clk_i);
      if (rst_ni && flash_req_o) begin
        d = slow_flash ? 2 : {$random(seed)} % 3;
        repeat (d) @(posedge clk_i);
        #1 flash_ack_i = 1'b1;
        @(posedge clk_i);
        // the address is still held by the host at the handshake edge
        a = req_data_i.addr;
        rd_cnt[a]++;
        #1 flash_ack_i = 1'b0;
        d = slow_flash ? 4 : 1 + {$random(seed)} % 4;
        repeat (d - 1) @(posedge clk_i);
        #1;
        flash_done_i        = 1'b1;
        flash_data_i.data   = flash_mem[a];
        // even parity, inverted for words on the error list
        flash_data_i.parity = (^flash_mem[a]) ^ bad_word[a];
        @(posedge clk_i);
        #1 flash_done_i = 1'b0;
      end
    end
  end

  // ends a run that stopped making progress
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout, the run did not finish within %0d cycles", MaxCycles);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // host tasks
  //////////////////////////////////////////////////

  // called and returning 1 ns after a rising edge
  task automatic issue_read(input logic [`FLASH_RD_ADDR_W-1:0] addr);
    req_i           = 1'b1;
    req_data_i.addr = addr;
    @(posedge clk_i);
    while (!rdy_o) @(posedge clk_i);
    #1 req_i = 1'b0;
  endtask

  task automatic wait_idle();
    @(posedge clk_i);
    while (!idle_o) @(posedge clk_i);
    #1;
  endtask

  task automatic send_maint(input maint_op_e op, input logic [`FLASH_RD_ADDR_W-1:0] addr);
    maint_i         = 1'b1;
    maint_op_i      = op;
    req_data_i.addr = addr;
    @(posedge clk_i);
    #1 maint_i = 1'b0;
  endtask

  task automatic expect_reads(input logic [`FLASH_RD_ADDR_W-1:0] addr, input int got,
                              input int exp);
    if (got != exp) begin
      $display("Error at %t: addr %h read flash %0d times, expected %0d",
               $time, addr, got, exp);
      tb_err++;
    end
  endtask

  // prints the result of one test once all its answers are back
  task automatic end_test(input string name);
    int errs;
    wait_idle();
    if (u_chk.expect_q.size() != 0) begin
      $display("%0d requests of test %s were never answered", u_chk.expect_q.size(), name);
      tb_err++;
    end
    errs = u_chk.err_cnt + tb_err + uut.u_assert.fail_cnt;
    if (errs == last_errs) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: FAILED with %0d errors", name, errs - last_errs);
    end
    last_errs = errs;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [`FLASH_RD_ADDR_W-1:0] hot [4];
    int                          base [4];
    logic [`FLASH_RD_ADDR_W-1:0] a;
    $timeformat(-9, 0, " ns", 0);
    rst_ni     = 1'b0;
    buf_en_i   = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    maint_i    = 1'b0;
    maint_op_i = OP_PROG;
    hot[0]     = 12'h010;
    hot[1]     = 12'h123;
    hot[2]     = 12'h456;
    hot[3]     = 12'h789;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // buffers off, every word comes straight from flash
    for (int i = 0; i < 16; i++) begin
      a = $random(seed);
      issue_read(a);
    end
    end_test("1 buffers off");

    // one warm-up round fills the four buffers, later rounds must all hit
    buf_en_i = 1'b1;
    for (int i = 0; i < 4; i++) begin
      base[i] = rd_cnt[hot[i]];
      issue_read(hot[i]);
    end
    wait_idle();
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 4; i++) begin
        issue_read(hot[i]);
      end
    end
    wait_idle();
    for (int i = 0; i < 4; i++) begin
      expect_reads(hot[i], rd_cnt[hot[i]] - base[i], 1);
    end
    end_test("2 repeat hits");

    // a word with broken parity is never served from a buffer
    bad_word[12'h0aa] = 1'b1;
    base[0] = rd_cnt[12'h0aa];
    issue_read(12'h0aa);
    wait_idle();
    issue_read(12'h0aa);
    wait_idle();
    expect_reads(12'h0aa, rd_cnt[12'h0aa] - base[0], 2);
    end_test("4 parity error");

    // every third request is a new word, the rest are likely hits
    slow_flash = 1'b1;
    for (int i = 0; i < 12; i++) begin
      if (i % 3 == 0) begin
        a = $random(seed);
      end else begin
        a = hot[i % 4];
      end
      issue_read(a);
    end
    end_test("5 mixed order");
    slow_flash = 1'b0;

    // the enable flips between requests, the pipeline drains before it lands
    for (int i = 0; i < 20; i++) begin
      if (i % 5 == 0 && i > 0) begin
        buf_en_i = ~buf_en_i;
      end
      a = 12'h200 + ({$random(seed)} % 8);
      issue_read(a);
    end
    buf_en_i = 1'b1;
    end_test("6 enable toggle");

    // program of a buffered word
    issue_read(12'h300);
    issue_read(12'h300);
    wait_idle();
    send_maint(OP_PROG, 12'h300);
    flash_mem[12'h300] = $random(seed);
    issue_read(12'h300);
    wait_idle();
    // page erase, the page being the upper six address bits
    issue_read(12'h340);
    issue_read(12'h341);
    wait_idle();
    send_maint(OP_PG_ERASE, 12'h340);
    for (int i = 12'h340; i < 12'h380; i++) begin
      flash_mem[i] = '1;
    end
    issue_read(12'h340);
    wait_idle();
    // bank erase clears the whole macro
    issue_read(hot[0]);
    wait_idle();
    send_maint(OP_BK_ERASE, '0);
    for (int i = 0; i < NumWords; i++) begin
      flash_mem[i] = '1;
    end
    issue_read(hot[0]);
    end_test("3 program and erase");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
flash_rd_pkg.sv
flash_rd_ctrl.sv
flash_rd_buf_array.sv
flash_rd_rsp_fifo.sv
flash_rd_rsp.sv
flash_rd_top.sv
tb_flash_rd_assert.sv
tb_flash_rd_chk.sv
tb_flash_rd.sv

// ==== Bender.yml ====
package:
  name: flash_rd

sources:
  - include_dirs:
      - .
    files:
      - flash_rd_pkg.sv
      - flash_rd_ctrl.sv
      - flash_rd_buf_array.sv
      - flash_rd_rsp_fifo.sv
      - flash_rd_rsp.sv
      - flash_rd_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_flash_rd_assert.sv
      - tb_flash_rd_chk.sv
      - tb_flash_rd.sv
